//--- verilog.f
+incdir+include
hw/qspi_bus_pkg.sv
hw/qspi_link_pkg.sv
hw/qspi_io.sv
hw/nor_read_seq.sv
hw/qspi_cfg_regs.sv
hw/qspi_xip_top.sv
verif/nor_flash_model.sv
verif/tb_qspi_xip.sv

//--- verif/tb_qspi_xip.sv
`include "qspi_settings.svh"

module tb_qspi_xip;
    timeunit 1ns;
    timeprecision 100ps;

    import qspi_bus_pkg::*;

    localparam int MAX_CYCLES = 40 * 250 + 2000; // reads times worst case, plus reg traffic

    logic                        clk;
    logic                        rstn;
    logic [`QSPI_NOR_ADDR_W-1:0] nor_addr;
    logic                        nor_w_rb;
    acc_e                        nor_acc;
    logic                        nor_req;
    logic [`QSPI_BUS_W-1:0]      nor_rdata;
    logic                        nor_resp;
    logic                        nor_fault;
    logic [`QSPI_REG_ADDR_W-1:0] reg_addr;
    logic                        reg_w_rb;
    acc_e                        reg_acc;
    logic [`QSPI_BUS_W-1:0]      reg_wdata;
    logic                        reg_req;
    logic [`QSPI_BUS_W-1:0]      reg_rdata;
    logic                        reg_resp;
    logic                        reg_fault;
    logic                        spi_csb;
    logic                        spi_sclk;
    logic [3:0]                  spi_dir;
    logic [3:0]                  spi_mosi;
    logic [3:0]                  spi_miso;

    // expectations
    logic        exp_reg_fault;
    logic        exp_nor_fault;
    logic        chk_reg_rd;
    logic [31:0] exp_reg_rdata;
    logic [31:0] exp_nor_rdata;
    logic        nor_pending;
    logic [2:0]  exp_mode;
    logic [7:0]  exp_cmd;
    logic [23:0] exp_addr;
    logic [3:0]  exp_dmy;
    logic        exp_dmy_dir;
    logic [3:0]  exp_pattern;
    int          exp_bytes;
    int          errors;
    int          flash_errs;
    int          cycles;

    qspi_xip_top DUT (.*);

    nor_flash_model u_flash (.*, .err_count(flash_errs));

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    a_csb_sclk: assert property (@(posedge clk) disable iff (!rstn) spi_csb |-> !spi_sclk)
        else begin
            errors++;
            $display("sclk toggled while csb was high");
        end
    a_reg_fault: assert property (@(posedge clk) disable iff (!rstn)
        reg_req |-> reg_fault == exp_reg_fault)
        else begin
            errors++;
            $display("FAILED reg_fault: got %h expected %h",
                     $sampled(reg_fault), $sampled(exp_reg_fault));
        end
    a_nor_fault: assert property (@(posedge clk) disable iff (!rstn)
        nor_req |-> nor_fault == exp_nor_fault)
        else begin
            errors++;
            $display("FAILED nor_fault: got %h expected %h",
                     $sampled(nor_fault), $sampled(exp_nor_fault));
        end
    // a faulting request must not start a read
    a_nor_fault_idle: assert property (@(posedge clk) disable iff (!rstn)
        (nor_req && nor_fault) |=> spi_csb)
        else begin
            errors++;
            $display("a faulting flash request started a read");
        end
    a_reg_resp_time: assert property (@(posedge clk) disable iff (!rstn)
        (reg_req && !reg_fault) |=> reg_resp)
        else begin
            errors++;
            $display("reg_resp missing one cycle after the request");
        end
    a_reg_resp_cause: assert property (@(posedge clk) disable iff (!rstn)
        reg_resp |-> $past(reg_req && !reg_fault))
        else begin
            errors++;
            $display("reg_resp without an accepted request");
        end
    a_reg_rdata: assert property (@(posedge clk) disable iff (!rstn)
        (reg_resp && chk_reg_rd) |-> reg_rdata == exp_reg_rdata)
        else begin
            errors++;
            $display("FAILED reg_rdata: got %h expected %h",
                     $sampled(reg_rdata), $sampled(exp_reg_rdata));
        end
    a_nor_resp_cause: assert property (@(posedge clk) disable iff (!rstn)
        nor_resp |-> nor_pending)
        else begin
            errors++;
            $display("nor_resp without an accepted read");
        end
    a_nor_rdata: assert property (@(posedge clk) disable iff (!rstn)
        nor_resp |-> nor_rdata == exp_nor_rdata)
        else begin
            errors++;
            $display("FAILED nor_rdata: got %h expected %h",
                     $sampled(nor_rdata), $sampled(exp_nor_rdata));
        end
    a_flash_ok: assert property (@(posedge clk) disable iff (!rstn)
        flash_errs == $past(flash_errs))
        else $display("flash model reported a mismatch");

    // flash byte n is the low address byte of addr+n xor 5a, first byte lowest
    function automatic logic [31:0] expected_word(input logic [23:0] a, input int n);
        logic [31:0] w;
        w = 32'h0;
        for (int i = 0; i < n; i++) begin
            w[8*i +: 8] = 8'(a + 24'(i)) ^ 8'h5a;
        end
        return w;
    endfunction

    task automatic reg_access(input logic [2:0] addr, input acc_e acc, input logic w_rb,
                              input logic [31:0] data, input logic bad,
                              input logic [31:0] exp_rd);
        @(posedge clk);
        reg_req       <= 1'b1;
        reg_addr      <= addr;
        reg_acc       <= acc;
        reg_w_rb      <= w_rb;
        reg_wdata     <= data;
        exp_reg_fault <= bad;
        chk_reg_rd    <= !w_rb;
        exp_reg_rdata <= exp_rd;
        @(posedge clk);
        reg_req <= 1'b0;
        repeat (2) @(posedge clk);
    endtask

    task automatic config_read(input logic [2:0] mode, input logic [3:0] dmy, input logic dir,
                               input logic [3:0] pattern, input logic [7:0] cmd);
        reg_access(3'd0, ACC_1B, 1'b1, {24'h0, cmd}, 1'b0, 32'h0);
        reg_access(3'd2, ACC_2B, 1'b1, {20'h0, pattern, dmy, dir, mode}, 1'b0, 32'h0);
        exp_mode    <= mode;
        exp_cmd     <= cmd;
        exp_dmy     <= dmy;
        exp_dmy_dir <= dir;
        exp_pattern <= pattern;
    endtask

    task automatic flash_read(input logic [23:0] addr, input acc_e acc, input int n);
        @(posedge clk);
        nor_req       <= 1'b1;
        nor_addr      <= addr;
        nor_acc       <= acc;
        nor_w_rb      <= 1'b0;
        exp_nor_fault <= 1'b0;
        exp_nor_rdata <= expected_word(addr, n);
        nor_pending   <= 1'b1;
        exp_addr      <= addr;
        exp_bytes     <= n;
        @(posedge clk);
        nor_req <= 1'b0;
        do @(negedge clk); while (!nor_resp);
        @(posedge clk);
        nor_pending <= 1'b0;
    endtask

    task automatic flash_bad_request(input logic [23:0] addr, input acc_e acc,
                                     input logic w_rb);
        @(posedge clk);
        nor_req       <= 1'b1;
        nor_addr      <= addr;
        nor_acc       <= acc;
        nor_w_rb      <= w_rb;
        exp_nor_fault <= 1'b1;
        @(posedge clk);
        nor_req <= 1'b0;
        repeat (4) @(posedge clk);
    endtask

    initial begin
        logic [31:0] r;
        logic [23:0] a;
        clk           = 0;
        rstn          = 0;
        nor_addr      = '0;
        nor_w_rb      = 0;
        nor_acc       = ACC_1B;
        nor_req       = 0;
        reg_addr      = '0;
        reg_w_rb      = 0;
        reg_acc       = ACC_1B;
        reg_wdata     = '0;
        reg_req       = 0;
        exp_reg_fault = 0;
        exp_nor_fault = 0;
        chk_reg_rd    = 0;
        exp_reg_rdata = 0;
        exp_nor_rdata = 0;
        nor_pending   = 0;
        exp_mode      = 0;
        exp_cmd       = 0;
        exp_addr      = 0;
        exp_dmy       = 0;
        exp_dmy_dir   = 0;
        exp_pattern   = 0;
        exp_bytes     = 0;
        errors        = 0;
        cycles        = 0;
        void'($urandom(32'hf83bc4b2));
        repeat (5) @(posedge clk);
        rstn <= 1'b1;
        @(negedge clk);
        assert (spi_csb === 1'b1 && spi_sclk === 1'b0 && nor_resp === 1'b0 && reg_resp === 1'b0)
            else begin
                errors++;
                $display("outputs not at their idle levels after reset");
            end

        // register readback
        repeat (3) begin
            r = $urandom;
            reg_access(3'd0, ACC_1B, 1'b1, r, 1'b0, 32'h0);
            reg_access(3'd0, ACC_1B, 1'b0, 32'h0, 1'b0, {24'h0, r[7:0]});
            r = $urandom;
            reg_access(3'd2, ACC_2B, 1'b1, r, 1'b0, 32'h0);
            reg_access(3'd2, ACC_2B, 1'b0, 32'h0, 1'b0, {20'h0, r[11:0]});
        end

        // faults
        for (int i = 3; i < 8; i++) begin
            reg_access(3'(i), ACC_1B, 1'b0, 32'h0, 1'b1, 32'h0);
        end
        reg_access(3'd1, ACC_2B, 1'b1, 32'h0, 1'b1, 32'h0);
        reg_access(3'd0, ACC_2B, 1'b1, 32'h0, 1'b1, 32'h0);
        reg_access(3'd2, ACC_1B, 1'b0, 32'h0, 1'b1, 32'h0);
        reg_access(3'd2, ACC_4B, 1'b1, 32'h0, 1'b1, 32'h0);
        flash_bad_request(24'h000100, ACC_1B, 1'b1);
        flash_bad_request(24'h000101, ACC_2B, 1'b0);
        flash_bad_request(24'h000103, ACC_4B, 1'b0);
        flash_bad_request(24'h000102, ACC_4B, 1'b0);

        // mode 111, no dummies
        config_read(3'd0, 4'd0, 1'b0, 4'h0, 8'($urandom));
        a = 24'($urandom);
        flash_read(a, ACC_1B, 1);
        flash_read(a & 24'hfffffe, ACC_2B, 2);
        flash_read(a & 24'hfffffc, ACC_4B, 4);

        for (int m = 1; m < 7; m++) begin
            config_read(3'(m), 4'($urandom_range(0, 15)), 1'($urandom), 4'($urandom),
                        8'($urandom));
            a = 24'($urandom);
            flash_read(a, ACC_1B, 1);
            flash_read(a & 24'hfffffe, ACC_2B, 2);
            flash_read(a & 24'hfffffc, ACC_4B, 4);
        end

        repeat (4) @(posedge clk);
        $display("errors: checks %0d, flash model %0d", errors, flash_errs);
        if (errors == 0 && flash_errs == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- verif/nor_flash_model.sv
module nor_flash_model (
    input  logic        spi_csb,
    input  logic        spi_sclk,
    input  logic [3:0]  spi_dir,
    input  logic [3:0]  spi_mosi,
    output logic [3:0]  spi_miso,
    input  logic [2:0]  exp_mode,
    input  logic [7:0]  exp_cmd,
    input  logic [23:0] exp_addr,
    input  logic [3:0]  exp_dmy,
    input  logic        exp_dmy_dir,
    input  logic [3:0]  exp_pattern,
    input  int          exp_bytes,
    output int          err_count
);
    timeunit 1ns;
    timeprecision 100ps;

    int          edges;
    int          cw;
    int          aw;
    int          dw;
    int          ce;
    int          ae;
    int          de;
    int          nd;
    logic        active;
    logic [7:0]  cmd_rx;
    logic [23:0] addr_rx;
    logic [7:0]  dbyte;
    logic [3:0]  bits;

    function automatic logic [3:0] mask_of(input int n);
        case (n)
            1:       return 4'b0001;
            2:       return 4'b0011;
            default: return 4'b1111;
        endcase
    endfunction

    // lanes per phase from the mode digits
    always @* begin
        cw = (exp_mode == 3'd6) ? 4 : (exp_mode == 3'd5) ? 2 : 1;
        aw = (exp_mode == 3'd4 || exp_mode == 3'd6) ? 4
           : (exp_mode == 3'd3 || exp_mode == 3'd5) ? 2 : 1;
        dw = (exp_mode == 3'd0) ? 1
           : (exp_mode == 3'd1 || exp_mode == 3'd3 || exp_mode == 3'd5) ? 2 : 4;
        ce = 8 / cw;
        ae = 24 / aw;
        de = exp_dmy;
    end

    task automatic check_dir(input string phase, input logic [3:0] exp);
        if (spi_dir !== exp) begin
            err_count++;
            $display("FAILED spi_dir in %s phase: got %h expected %h", phase, spi_dir, exp);
        end
    endtask

    initial begin
        spi_miso  = 4'h0;
        err_count = 0;
        active    = 1'b0;
        edges     = 0;
    end

    always @(negedge spi_csb) begin
        active  = 1'b1;
        edges   = 0;
        cmd_rx  = 8'h00;
        addr_rx = 24'h0;
    end

    always @(posedge spi_sclk) begin
        if (edges < ce) begin
            check_dir("command", mask_of(cw));
            cmd_rx = (cmd_rx << cw) | 8'(spi_mosi & mask_of(cw));
        end else if (edges < ce + ae) begin
            check_dir("address", mask_of(aw));
            addr_rx = (addr_rx << aw) | 24'(spi_mosi & mask_of(aw));
        end else if (edges < ce + ae + de) begin
            check_dir("dummy", exp_dmy_dir ? mask_of(aw) : 4'h0);
            if (exp_dmy_dir && (spi_mosi & mask_of(aw)) !== (exp_pattern & mask_of(aw))) begin
                err_count++;
                $display("FAILED spi_mosi in dummy phase: got %h expected %h",
                         spi_mosi & mask_of(aw), exp_pattern & mask_of(aw));
            end
        end else begin
            check_dir("data", 4'h0);
        end
        edges++;
    end

    // next group goes out just after each falling edge of the data phase
    always @(negedge spi_sclk) begin
        if (active && edges >= ce + ae + de) begin
            nd    = edges - (ce + ae + de);
            dbyte = 8'(addr_rx + 24'(nd / (8 / dw))) ^ 8'h5a;
            bits  = 4'(dbyte >> (8 - dw * (nd % (8 / dw) + 1))) & mask_of(dw);
            spi_miso <= #1 (dw == 1) ? {2'b00, bits[0], 1'b0} : bits;
        end
    end

    always @(posedge spi_csb) begin
        if (active) begin
            active = 1'b0;
            if (cmd_rx !== exp_cmd) begin
                err_count++;
                $display("FAILED command octet: got %h expected %h", cmd_rx, exp_cmd);
            end
            if (addr_rx !== exp_addr) begin
                err_count++;
                $display("FAILED flash address: got %h expected %h", addr_rx, exp_addr);
            end
            if (edges != ce + ae + de + exp_bytes * 8 / dw) begin
                err_count++;
                $display("flash model: saw %0d clocks in the read but expected %0d",
                         edges, ce + ae + de + exp_bytes * 8 / dw);
            end
        end
    end

endmodule

//--- hw/qspi_xip_top.sv
`include "qspi_settings.svh"

module qspi_xip_top (
    input  logic                        clk,
    input  logic                        rstn,
    input  logic [`QSPI_NOR_ADDR_W-1:0] nor_addr,
    input  logic                        nor_w_rb,
    input  qspi_bus_pkg::acc_e          nor_acc,
    input  logic                        nor_req,
    output logic [`QSPI_BUS_W-1:0]      nor_rdata,
    output logic                        nor_resp,
    output logic                        nor_fault,
    input  logic [`QSPI_REG_ADDR_W-1:0] reg_addr,
    input  logic                        reg_w_rb,
    input  qspi_bus_pkg::acc_e          reg_acc,
    input  logic [`QSPI_BUS_W-1:0]      reg_wdata,
    input  logic                        reg_req,
    output logic [`QSPI_BUS_W-1:0]      reg_rdata,
    output logic                        reg_resp,
    output logic                        reg_fault,
    output logic                        spi_csb,
    output logic                        spi_sclk,
    output logic [3:0]                  spi_dir,
    output logic [3:0]                  spi_mosi,
    input  logic [3:0]                  spi_miso
);
    import qspi_link_pkg::*;

    // cfg to sequencer and serializer
    lane_width_e                cmd_width;
    lane_width_e                addr_width;
    lane_width_e                data_width;
    logic [7:0]                 cmd_octet;
    logic [`QSPI_DMY_CNT_W-1:0] dmy_cnt;
    logic                       dmy_dir;
    logic [3:0]                 dmy_pattern;

    // sequencer to serializer
    lane_width_e                width;
    logic                       tx_req;
    logic [7:0]                 tx_byte;
    logic                       tx_done;
    logic                       rx_req;
    logic [7:0]                 rx_byte;
    logic                       rx_done;
    logic                       dmy_req;
    logic                       dmy_done;

    qspi_cfg_regs u_cfg_regs (.*);

    nor_read_seq u_read_seq (.*);

    qspi_io u_io (.*);

endmodule

//--- hw/qspi_cfg_regs.sv
`include "qspi_settings.svh"

module qspi_cfg_regs (
    input  logic                        clk,
    input  logic                        rstn,
    input  logic [`QSPI_REG_ADDR_W-1:0] reg_addr,
    input  logic                        reg_w_rb,
    input  qspi_bus_pkg::acc_e          reg_acc,
    input  logic [`QSPI_BUS_W-1:0]      reg_wdata,
    input  logic                        reg_req,
    output logic [`QSPI_BUS_W-1:0]      reg_rdata,
    output logic                        reg_resp,
    output logic                        reg_fault,
    output qspi_link_pkg::lane_width_e  cmd_width,
    output qspi_link_pkg::lane_width_e  addr_width,
    output qspi_link_pkg::lane_width_e  data_width,
    output logic [7:0]                  cmd_octet,
    output logic [`QSPI_DMY_CNT_W-1:0]  dmy_cnt,
    output logic                        dmy_dir,
    output logic [3:0]                  dmy_pattern
);
    import qspi_bus_pkg::*;
    import qspi_link_pkg::*;

    logic [7:0]                norcmd;
    logic [`QSPI_NORCSR_W-1:0] norcsr; // pattern 11:8, count 7:4, dir 3, mode 2:0
    logic                      invld;
    logic                      hit;
    read_mode_e                mode;

    always_comb begin
        case (reg_addr)
            REG_NORCMD: invld = (reg_acc != ACC_1B);
            REG_NORCSR: invld = (reg_acc != ACC_2B);
            default:    invld = 1'b1;
        endcase
    end

    assign reg_fault = reg_req & invld;
    assign hit       = reg_req & ~invld;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            norcmd   <= 8'd0;
            norcsr   <= '0;
            reg_resp <= 1'b0;
        end else begin
            reg_resp <= hit;
            if (hit && reg_w_rb && reg_addr == REG_NORCMD) begin
                norcmd <= reg_wdata[7:0];
            end else if (hit && reg_w_rb) begin
                norcsr <= reg_wdata[`QSPI_NORCSR_W-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (hit && !reg_w_rb && reg_addr == REG_NORCMD) begin
            reg_rdata <= {{(`QSPI_BUS_W-8){1'b0}}, norcmd};
        end else if (hit && !reg_w_rb) begin
            reg_rdata <= {{(`QSPI_BUS_W-`QSPI_NORCSR_W){1'b0}}, norcsr};
        end
    end

    assign cmd_octet   = norcmd;
    assign dmy_pattern = norcsr[11:8];
    assign dmy_cnt     = norcsr[4 +: `QSPI_DMY_CNT_W];
    assign dmy_dir     = norcsr[3]; // 1 drives the pattern
    assign mode        = read_mode_e'(norcsr[2:0]);

    // mode 7 falls back to 111
    always_comb begin
        cmd_width  = LANE_X1;
        addr_width = LANE_X1;
        data_width = LANE_X1;
        case (mode)
            MODE_112: data_width = LANE_X2;
            MODE_114: data_width = LANE_X4;
            MODE_122: begin
                addr_width = LANE_X2;
                data_width = LANE_X2;
            end
            MODE_144: begin
                addr_width = LANE_X4;
                data_width = LANE_X4;
            end
            MODE_222: begin
                cmd_width  = LANE_X2;
                addr_width = LANE_X2;
                data_width = LANE_X2;
            end
            MODE_444: begin
                cmd_width  = LANE_X4;
                addr_width = LANE_X4;
                data_width = LANE_X4;
            end
            default: ;
        endcase
    end

endmodule

//--- hw/nor_read_seq.sv
`include "qspi_settings.svh"

module nor_read_seq (
    input  logic                        clk,
    input  logic                        rstn,
    input  logic [`QSPI_NOR_ADDR_W-1:0] nor_addr,
    input  logic                        nor_w_rb,
    input  qspi_bus_pkg::acc_e          nor_acc,
    input  logic                        nor_req,
    output logic [`QSPI_BUS_W-1:0]      nor_rdata,
    output logic                        nor_resp,
    output logic                        nor_fault,
    input  qspi_link_pkg::lane_width_e  cmd_width,
    input  qspi_link_pkg::lane_width_e  addr_width,
    input  qspi_link_pkg::lane_width_e  data_width,
    input  logic [7:0]                  cmd_octet,
    input  logic [`QSPI_DMY_CNT_W-1:0]  dmy_cnt,
    output qspi_link_pkg::lane_width_e  width,
    output logic                        tx_req,
    output logic [7:0]                  tx_byte,
    input  logic                        tx_done,
    output logic                        rx_req,
    input  logic [7:0]                  rx_byte,
    input  logic                        rx_done,
    output logic                        dmy_req,
    input  logic                        dmy_done,
    output logic                        spi_csb
);
    import qspi_bus_pkg::*;
    import qspi_link_pkg::*;

    logic                        invld;
    logic                        accept;
    logic [`QSPI_NOR_ADDR_W-1:0] req_addr;
    acc_e                        req_acc;
    logic [1:0]                  last_idx;
    seq_state_e                  state;
    seq_state_e                  next_state;
    logic [`QSPI_DMY_CNT_W-1:0]  cnt;
    logic [`QSPI_DMY_CNT_W-1:0]  next_cnt;
    logic                        rx_q;
    logic                        last_q;
    logic [1:0]                  byte_idx;

    assign invld = nor_w_rb
                || (nor_addr[0] && nor_acc != ACC_1B)
                || (nor_addr[1:0] == 2'd2 && nor_acc == ACC_4B);
    assign nor_fault = nor_req & invld;
    assign accept    = nor_req & ~invld & (state == SEQ_IDLE);

    always_comb begin
        case (req_acc)
            ACC_4B:  last_idx = 2'd3;
            ACC_2B:  last_idx = 2'd1;
            default: last_idx = 2'd0;
        endcase
    end

    // requests go out in the done cycle so items run back to back
    always_comb begin
        next_state = state;
        next_cnt   = cnt;
        width      = addr_width; // also the dummy width
        tx_req     = 1'b0;
        tx_byte    = cmd_octet;
        rx_req     = 1'b0;
        dmy_req    = 1'b0;
        case (state)
            SEQ_IDLE: begin
                if (accept) begin
                    next_state = SEQ_PREP;
                end
            end
            SEQ_PREP: begin
                width      = cmd_width;
                tx_req     = 1'b1;
                next_state = SEQ_CMD;
            end
            SEQ_CMD: begin
                if (tx_done) begin
                    tx_req     = 1'b1;
                    tx_byte    = req_addr[23:16];
                    next_state = SEQ_ADDR;
                    next_cnt   = 'd2;
                end
            end
            SEQ_ADDR: begin
                if (tx_done && cnt != 'd0) begin
                    tx_req   = 1'b1;
                    tx_byte  = (cnt == 'd2) ? req_addr[15:8] : req_addr[7:0];
                    next_cnt = cnt - 'd1;
                end else if (tx_done && dmy_cnt != 'd0) begin
                    dmy_req    = 1'b1;
                    next_state = SEQ_DMY;
                    next_cnt   = dmy_cnt;
                end else if (tx_done) begin
                    width      = data_width;
                    rx_req     = 1'b1;
                    next_state = SEQ_DATA;
                    next_cnt   = `QSPI_DMY_CNT_W'(last_idx);
                end
            end
            SEQ_DMY: begin
                if (dmy_done && cnt == 'd1) begin
                    width      = data_width;
                    rx_req     = 1'b1;
                    next_state = SEQ_DATA;
                    next_cnt   = `QSPI_DMY_CNT_W'(last_idx);
                end else if (dmy_done) begin
                    dmy_req  = 1'b1;
                    next_cnt = cnt - 'd1;
                end
            end
            SEQ_DATA: begin
                width = data_width;
                if (rx_done && cnt == 'd0) begin
                    next_state = SEQ_IDLE;
                end else if (rx_done) begin
                    rx_req   = 1'b1;
                    next_cnt = cnt - 'd1;
                end
            end
            default: next_state = SEQ_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state    <= SEQ_IDLE;
            cnt      <= '0;
            spi_csb  <= 1'b1;
            rx_q     <= 1'b0;
            last_q   <= 1'b0;
            nor_resp <= 1'b0;
        end else begin
            state <= next_state;
            cnt   <= next_cnt;
            if (next_state == SEQ_PREP) begin
                spi_csb <= 1'b0;
            end else if (next_state == SEQ_IDLE) begin
                spi_csb <= 1'b1;
            end
            rx_q     <= rx_done && (state == SEQ_DATA);
            last_q   <= rx_done && (state == SEQ_DATA) && (cnt == 'd0);
            nor_resp <= last_q; // last byte lands in rdata with it
        end
    end

    // little endian, first byte to 7:0
    always_ff @(posedge clk) begin
        if (accept) begin
            req_addr  <= nor_addr;
            req_acc   <= nor_acc;
            nor_rdata <= '0;
            byte_idx  <= 2'd0;
        end else if (rx_q) begin
            nor_rdata[8*byte_idx +: 8] <= rx_byte;
            byte_idx                   <= byte_idx + 2'd1;
        end
    end

    a_resp_after_data: assert property (@(posedge clk) disable iff (!rstn)
        nor_resp == ($past(state, 2) == SEQ_DATA && $past(state) != SEQ_DATA));

endmodule

//--- hw/qspi_io.sv
`include "qspi_settings.svh"

module qspi_io (
    input  logic                       clk,
    input  logic                       rstn,
    input  qspi_link_pkg::lane_width_e width,
    input  logic                       tx_req,
    input  logic [7:0]                 tx_byte,
    output logic                       tx_done,
    input  logic                       rx_req,
    output logic [7:0]                 rx_byte,
    output logic                       rx_done,
    input  logic                       dmy_req,
    input  logic                       dmy_dir,
    input  logic [3:0]                 dmy_pattern,
    output logic                       dmy_done,
    output logic                       spi_sclk,
    output logic [3:0]                 spi_dir,
    output logic [3:0]                 spi_mosi,
    input  logic [3:0]                 spi_miso
);
    import qspi_link_pkg::*;

    io_state_e   state;
    logic [3:0]  cnt;
    logic [3:0]  first_cnt;
    logic        last;
    lane_width_e cur_width;
    logic [7:0]  tx_hold;
    logic [3:0]  lane_mask;

    // two cycles per bit time
    always_comb begin
        case (width)
            LANE_X1: first_cnt = 4'd15;
            LANE_X2: first_cnt = 4'd7;
            default: first_cnt = 4'd3;
        endcase
    end

    assign last = (cnt == 4'd0); // idle or final cycle of an item

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state     <= IO_IDLE;
            cnt       <= 4'd0;
            cur_width <= LANE_X1;
        end else if (last) begin
            cur_width <= width;
            if (tx_req) begin
                state <= IO_TX;
                cnt   <= first_cnt;
            end else if (rx_req) begin
                state <= IO_RX;
                cnt   <= first_cnt;
            end else if (dmy_req) begin
                state <= dmy_dir ? IO_DMY_O : IO_DMY_I;
                cnt   <= 4'd1;
            end else begin
                state <= IO_IDLE;
            end
        end else begin
            cnt <= cnt - 4'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (last && tx_req) begin
            tx_hold <= tx_byte;
        end
    end

    assign tx_done  = (state == IO_TX) && last;
    assign rx_done  = (state == IO_RX) && last;
    assign dmy_done = (state == IO_DMY_O || state == IO_DMY_I) && last;

    // low half then high half of each bit
    assign spi_sclk = (state == IO_IDLE) ? `QSPI_SCLK_IDLE : ~cnt[0];

    always_comb begin
        case (cur_width)
            LANE_X1: lane_mask = 4'b0001;
            LANE_X2: lane_mask = 4'b0011;
            default: lane_mask = 4'b1111;
        endcase
    end

    assign spi_dir = (state == IO_TX || state == IO_DMY_O) ? lane_mask : 4'b0000;

    always_comb begin
        spi_mosi = 4'b0000;
        if (state == IO_TX) begin
            case (cur_width)
                LANE_X1: spi_mosi = {3'b000, tx_hold[cnt[3:1]]};
                LANE_X2: spi_mosi = {2'b00, tx_hold[{cnt[2:1], 1'b0} +: 2]};
                default: spi_mosi = tx_hold[{cnt[1], 2'b00} +: 4];
            endcase
        end else if (state == IO_DMY_O) begin
            spi_mosi = dmy_pattern;
        end
    end

    // x1 data comes back on io1
    always_ff @(posedge clk) begin
        if (state == IO_RX) begin
            case (cur_width)
                LANE_X1: rx_byte[cnt[3:1]] <= spi_miso[1];
                LANE_X2: rx_byte[{cnt[2:1], 1'b0} +: 2] <= spi_miso[1:0];
                default: rx_byte[{cnt[1], 2'b00} +: 4] <= spi_miso;
            endcase
        end
    end

    a_one_req: assert property (@(posedge clk) disable iff (!rstn)
        $onehot0({tx_req, rx_req, dmy_req}));

    a_req_when_free: assert property (@(posedge clk) disable iff (!rstn)
        (tx_req || rx_req || dmy_req) |-> last);

endmodule

//--- hw/qspi_link_pkg.sv
package qspi_link_pkg;

    typedef enum logic [1:0] {
        LANE_X1 = 2'd0,
        LANE_X2 = 2'd1,
        LANE_X4 = 2'd2
    } lane_width_e;

    // cmd/addr/data lane widths, NORCSR[2:0]
    typedef enum logic [2:0] {
        MODE_111 = 3'd0,
        MODE_112 = 3'd1,
        MODE_114 = 3'd2,
        MODE_122 = 3'd3,
        MODE_144 = 3'd4,
        MODE_222 = 3'd5,
        MODE_444 = 3'd6
    } read_mode_e;

    typedef enum logic [2:0] {
        IO_IDLE,
        IO_TX,
        IO_RX,
        IO_DMY_O,
        IO_DMY_I
    } io_state_e;

    typedef enum logic [2:0] {
        SEQ_IDLE,
        SEQ_PREP,
        SEQ_CMD,
        SEQ_ADDR,
        SEQ_DMY,
        SEQ_DATA
    } seq_state_e;

endpackage

//--- hw/qspi_bus_pkg.sv
`include "qspi_settings.svh"

package qspi_bus_pkg;

    // bus access size
    typedef enum logic [1:0] {
        ACC_1B = 2'd0,
        ACC_2B = 2'd1,
        ACC_4B = 2'd2
    } acc_e;

    // register map, unlisted offsets fault
    typedef enum logic [`QSPI_REG_ADDR_W-1:0] {
        REG_NORCMD = `QSPI_NORCMD_OFS,
        REG_NORCSR = `QSPI_NORCSR_OFS
    } reg_addr_e;

endpackage

//--- include/qspi_settings.svh
`ifndef QSPI_SETTINGS_SVH
`define QSPI_SETTINGS_SVH

// flash byte address, 3-byte addressing only
`define QSPI_NOR_ADDR_W 24

`define QSPI_BUS_W 32
`define QSPI_REG_ADDR_W 3

// register offsets
`define QSPI_NORCMD_OFS 0
`define QSPI_NORCSR_OFS 2

`define QSPI_DMY_CNT_W 4
`define QSPI_NORCSR_W 12

`define QSPI_SCLK_IDLE 1'b0 // mode 0 idle level

`endif
